/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = zverif_tb
FILELIST = zverif_top.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* src/umi_endpoint_ctrl.sv */
module umi_endpoint_ctrl (
	input logic clk,
	input logic reset,
	umi_msg_if.sink req,
	umi_msg_if.source rsp,
	output logic mem_write_en,
	output zverif_pkg::mem_addr_t mem_index,
	output zverif_pkg::data_t mem_write_data,
	input zverif_pkg::data_t mem_read_data,
	output logic trap,
	output logic trace_valid,
	output zverif_pkg::trace_t trace_data
);

	zverif_pkg::ctrl_state_t state;
	zverif_pkg::ctrl_state_t state_next;
	zverif_pkg::opcode_t op_q;
	zverif_pkg::addr_t addr_q;
	zverif_pkg::data_t data_q;
	logic req_take;
	logic req_legal;
	logic rsp_take;
	logic is_write;

	assign req.ready = (state == zverif_pkg::idle);
	assign req_take = req.valid && req.ready;
	assign rsp_take = rsp.valid && rsp.ready;

	// Only read and write are served
	assign req_legal = (req.opcode == zverif_pkg::op_read)
		|| (req.opcode == zverif_pkg::op_write);
	assign is_write = (op_q == zverif_pkg::op_write);

	always_comb begin
		state_next = state;
		case (state)
			zverif_pkg::idle: begin
				if (req_take) begin
					state_next = req_legal ? zverif_pkg::access : zverif_pkg::trapped;
				end
			end
			zverif_pkg::access: begin
				state_next = zverif_pkg::respond;
			end
			zverif_pkg::respond: begin
				if (rsp_take) begin
					state_next = zverif_pkg::idle;
				end
			end
			// Trapped is left only through reset
			default: begin
				state_next = state;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= zverif_pkg::idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (req_take) begin
			op_q <= req.opcode;
			addr_q <= req.addr;
			data_q <= req.data;
		end
	end

	// Index stays on the latched address, so read data holds through respond
	assign mem_index = addr_q[zverif_pkg::mem_index_lsb +: $bits(zverif_pkg::mem_addr_t)];
	assign mem_write_en = (state == zverif_pkg::access) && is_write;
	assign mem_write_data = data_q;

	assign rsp.valid = (state == zverif_pkg::respond);
	assign rsp.opcode = is_write ? zverif_pkg::op_write_ack : zverif_pkg::op_read_resp;
	assign rsp.addr = addr_q;
	assign rsp.data = is_write ? data_q : mem_read_data;

	assign trap = (state == zverif_pkg::trapped);
	assign trace_valid = rsp_take;
	assign trace_data = {op_q, addr_q[zverif_pkg::trace_addr_bits-1:0]};

	// Once trapped, stays trapped and silent
	a_trap_silent: assert property (
		@(posedge clk) disable iff (reset)
		trap |=> trap && !rsp.valid
	);

	// Trace is a single-cycle pulse on a response take
	a_trace_pulse: assert property (
		@(posedge clk) disable iff (reset)
		trace_valid |-> (rsp.valid && rsp.ready) ##1 !trace_valid
	);

endmodule

/* src/umi_msg_if.sv */
// One decoded UMI message with a valid/ready handshake
interface umi_msg_if;

	logic valid;
	logic ready;
	zverif_pkg::opcode_t opcode;
	zverif_pkg::addr_t addr;
	zverif_pkg::data_t data;

	modport source (
		output valid,
		output opcode,
		output addr,
		output data,
		input ready
	);

	modport sink (
		input valid,
		input opcode,
		input addr,
		input data,
		output ready
	);

endinterface

/* src/umi_rx_port.sv */
module umi_rx_port (
	input logic clk,
	input logic reset,
	input zverif_pkg::umi_packet_t umi_packet_rx,
	input logic umi_valid_rx,
	output logic umi_ready_rx,
	umi_msg_if.source req
);

	zverif_pkg::umi_packet_t packet_q;
	logic full;

	// Single entry, so accept only while empty
	assign umi_ready_rx = !full;

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
		end else if (umi_valid_rx && umi_ready_rx) begin
			full <= 1'b1;
		end else if (req.valid && req.ready) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (umi_valid_rx && umi_ready_rx) begin
			packet_q <= umi_packet_rx;
		end
	end

	// Decoded view of the held packet
	assign req.valid = full;
	assign req.opcode = packet_q[zverif_pkg::opcode_msb:zverif_pkg::opcode_lsb];
	assign req.addr = packet_q[zverif_pkg::addr_msb:zverif_pkg::addr_lsb];
	assign req.data = packet_q[zverif_pkg::data_msb:zverif_pkg::data_lsb];

	// Message must hold until the controller takes it
	a_req_stable: assert property (
		@(posedge clk) disable iff (reset)
		req.valid && !req.ready |=> req.valid && $stable(req.opcode)
			&& $stable(req.addr) && $stable(req.data)
	);

endmodule

/* src/umi_tx_port.sv */
module umi_tx_port (
	input logic clk,
	input logic reset,
	umi_msg_if.sink rsp,
	output zverif_pkg::umi_packet_t umi_packet_tx,
	output logic umi_valid_tx,
	input logic umi_ready_tx
);

	zverif_pkg::umi_packet_t packet_d;
	zverif_pkg::umi_packet_t packet_q;
	logic full;

	assign rsp.ready = !full;

	// Unused fields go out as zero
	always_comb begin
		packet_d = '0;
		packet_d[zverif_pkg::opcode_msb:zverif_pkg::opcode_lsb] = rsp.opcode;
		packet_d[zverif_pkg::addr_msb:zverif_pkg::addr_lsb] = rsp.addr;
		packet_d[zverif_pkg::data_msb:zverif_pkg::data_lsb] = rsp.data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
		end else if (rsp.valid && rsp.ready) begin
			full <= 1'b1;
		end else if (umi_valid_tx && umi_ready_tx) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp.valid && rsp.ready) begin
			packet_q <= packet_d;
		end
	end

	assign umi_valid_tx = full;
	assign umi_packet_tx = packet_q;

	// Host back-pressure must not disturb the offered packet
	a_tx_stable: assert property (
		@(posedge clk) disable iff (reset)
		umi_valid_tx && !umi_ready_tx |=> umi_valid_tx && $stable(umi_packet_tx)
	);

endmodule

/* src/word_mem.sv */
module word_mem (
	input logic clk,
	input logic write_en,
	input zverif_pkg::mem_addr_t index,
	input zverif_pkg::data_t write_data,
	output zverif_pkg::data_t read_data
);

	zverif_pkg::data_t mem [zverif_pkg::mem_depth];

	always_ff @(posedge clk) begin
		if (write_en) begin
			mem[index] <= write_data;
		end
	end

	// Registered read, old contents on a same-cycle write
	always_ff @(posedge clk) begin
		read_data <= mem[index];
	end

	// Controller must present a known index on every write
	a_index_known: assert property (
		@(posedge clk)
		write_en |-> !$isunknown(index)
	);

endmodule

/* src/zverif_pkg.sv */
package zverif_pkg;

	// Sizes
	localparam int packet_width = 256;
	localparam int mem_depth = 64;

	// Field positions inside a UMI packet
	localparam int opcode_lsb = 0;
	localparam int opcode_msb = 7;
	localparam int addr_lsb = 32;
	localparam int addr_msb = 63;
	localparam int data_lsb = 96;
	localparam int data_msb = 127;

	// Word index is taken from byte address bits 7:2
	localparam int mem_index_lsb = 2;

	// Low address bits carried in a trace word
	localparam int trace_addr_bits = 24;

	typedef logic [packet_width-1:0] umi_packet_t;
	typedef logic [7:0] opcode_t;
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [$clog2(mem_depth)-1:0] mem_addr_t;
	typedef logic [31:0] trace_t;

	// Request codes
	localparam opcode_t op_read = 8'h01;
	localparam opcode_t op_write = 8'h02;

	// Response codes
	localparam opcode_t op_read_resp = 8'h81;
	localparam opcode_t op_write_ack = 8'h82;

	// Endpoint controller
	typedef enum logic [1:0] {
		idle,
		access,
		respond,
		trapped
	} ctrl_state_t;

endpackage

/* src/zverif_top.sv */
module zverif_top (
	input logic clk,
	input logic reset,

	// Request port
	input zverif_pkg::umi_packet_t umi_packet_rx,
	input logic umi_valid_rx,
	output logic umi_ready_rx,

	// Response port
	output zverif_pkg::umi_packet_t umi_packet_tx,
	output logic umi_valid_tx,
	input logic umi_ready_tx,

	// Request-level status
	output logic trap,
	output logic trace_valid,
	output zverif_pkg::trace_t trace_data
);

	logic mem_write_en;
	zverif_pkg::mem_addr_t mem_index;
	zverif_pkg::data_t mem_write_data;
	zverif_pkg::data_t mem_read_data;

	umi_msg_if req_msg ();
	umi_msg_if rsp_msg ();

	umi_rx_port umi_rx_port_i (
		.clk(clk),
		.reset(reset),
		.umi_packet_rx(umi_packet_rx),
		.umi_valid_rx(umi_valid_rx),
		.umi_ready_rx(umi_ready_rx),
		.req(req_msg.source)
	);

	umi_endpoint_ctrl umi_endpoint_ctrl_i (
		.clk(clk),
		.reset(reset),
		.req(req_msg.sink),
		.rsp(rsp_msg.source),
		.mem_write_en(mem_write_en),
		.mem_index(mem_index),
		.mem_write_data(mem_write_data),
		.mem_read_data(mem_read_data),
		.trap(trap),
		.trace_valid(trace_valid),
		.trace_data(trace_data)
	);

	word_mem word_mem_i (
		.clk(clk),
		.write_en(mem_write_en),
		.index(mem_index),
		.write_data(mem_write_data),
		.read_data(mem_read_data)
	);

	umi_tx_port umi_tx_port_i (
		.clk(clk),
		.reset(reset),
		.rsp(rsp_msg.sink),
		.umi_packet_tx(umi_packet_tx),
		.umi_valid_tx(umi_valid_tx),
		.umi_ready_tx(umi_ready_tx)
	);

endmodule

/* test/zverif_tb.sv */
module zverif_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_req = 40;
	// Legal requests, then the illegal one, then one left in the rx buffer
	localparam int n_total = n_req + 2;
	localparam int cycle_limit = 40 * n_total + 200;

	logic clk;
	logic reset;
	zverif_pkg::umi_packet_t umi_packet_rx;
	logic umi_valid_rx;
	logic umi_ready_rx;
	zverif_pkg::umi_packet_t umi_packet_tx;
	logic umi_valid_tx;
	logic umi_ready_tx;
	logic trap;
	logic trace_valid;
	zverif_pkg::trace_t trace_data;

	zverif_pkg::umi_packet_t exp_rsp [n_total];
	zverif_pkg::trace_t exp_trace [n_total];
	int rsp_count;
	int trace_count;
	int errors = 0;

	zverif_top zverif_top_i (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Opcode 7:0, address 63:32, data 127:96, everything else zero
	function automatic zverif_pkg::umi_packet_t build_packet(input zverif_pkg::opcode_t op,
			input zverif_pkg::addr_t addr, input zverif_pkg::data_t data);
		zverif_pkg::umi_packet_t p;
		p = '0;
		p[7:0] = op;
		p[63:32] = addr;
		p[127:96] = data;
		return p;
	endfunction

	task automatic log_failure(input string msg);
		errors++;
		$display("FAILED %0t: %s", $time, msg);
	endtask

	// Holds valid until the request port takes the packet
	task automatic send_request(input zverif_pkg::umi_packet_t pkt);
		logic taken;
		umi_packet_rx = pkt;
		umi_valid_rx = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = umi_ready_rx;
			@(posedge clk);
			#10;
		end
		umi_valid_rx = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Host side of the response port is ready about three cycles in four
	initial begin
		logic [31:0] bp;
		bp = 32'hfe87;
		umi_ready_tx = 1'b0;
		forever begin
			@(posedge clk);
			#10;
			bp = xorshift(bp);
			umi_ready_tx = bp[4] | bp[11];
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			rsp_count <= 0;
			trace_count <= 0;
		end else begin
			if (umi_valid_tx && umi_ready_tx) begin
				rsp_count <= rsp_count + 1;
			end
			if (trace_valid) begin
				trace_count <= trace_count + 1;
			end
		end
	end

	rsp_check: assert property (@(posedge clk) disable iff (reset)
		umi_valid_tx && umi_ready_tx |-> umi_packet_tx == exp_rsp[rsp_count])
		else log_failure("response packet differs from the reference model");
	tx_hold_check: assert property (@(posedge clk) disable iff (reset)
		umi_valid_tx && !umi_ready_tx |=> umi_valid_tx && $stable(umi_packet_tx))
		else log_failure("response packet changed under back-pressure");
	trace_check: assert property (@(posedge clk) disable iff (reset)
		trace_valid |-> trace_data == exp_trace[trace_count])
		else log_failure("trace word differs from the request");
	trace_pulse_check: assert property (@(posedge clk) disable iff (reset)
		trace_valid |=> !trace_valid)
		else log_failure("trace_valid longer than one cycle");
	trap_hold_check: assert property (@(posedge clk) disable iff (reset)
		trap |=> trap)
		else log_failure("trap dropped without reset");
	trap_quiet_check: assert property (@(posedge clk) disable iff (reset)
		trap |-> !umi_valid_tx && !trace_valid)
		else log_failure("response or trace seen after trap");

	initial begin
		zverif_pkg::data_t ref_mem [zverif_pkg::mem_depth];
		logic [zverif_pkg::mem_depth-1:0] written;
		logic [31:0] stim;
		zverif_pkg::opcode_t op;
		zverif_pkg::addr_t addr;
		zverif_pkg::mem_addr_t idx;
		zverif_pkg::mem_addr_t last_idx;
		zverif_pkg::umi_packet_t pkt;
		umi_packet_rx = '0;
		umi_valid_rx = 1'b0;
		reset = 1'b1;
		written = '0;
		last_idx = '0;
		stim = 32'hfe87;
		repeat (3) @(posedge clk);
		#10;
		reset = 1'b0;
		assert (!umi_valid_tx && !trap && !trace_valid && umi_ready_rx)
			else log_failure("outputs not at their reset values");
		for (int i = 0; i < n_req; i++) begin
			stim = xorshift(stim);
			op = (written == '0 || stim[0]) ? zverif_pkg::op_write : zverif_pkg::op_read;
			stim = xorshift(stim);
			addr = stim;
			idx = addr[7:2];
			// Reads go to written words only while upper address bits stay random
			if (op == zverif_pkg::op_read && !written[idx]) begin
				idx = last_idx;
				addr[7:2] = idx;
			end
			stim = xorshift(stim);
			if (op == zverif_pkg::op_write) begin
				ref_mem[idx] = stim;
				written[idx] = 1'b1;
				last_idx = idx;
				exp_rsp[i] = build_packet(zverif_pkg::op_write_ack, addr, stim);
			end else begin
				exp_rsp[i] = build_packet(zverif_pkg::op_read_resp, addr, ref_mem[idx]);
			end
			exp_trace[i] = {op, addr[23:0]};
			// Junk in unused request bits
			pkt = build_packet(op, addr, stim);
			pkt[255:224] = ~stim;
			send_request(pkt);
		end
		while (rsp_count < n_req) @(negedge clk);
		@(posedge clk);
		#10;
		send_request(build_packet(8'h07, 32'h0000_0040, 32'h0));
		while (!trap) @(negedge clk);
		@(posedge clk);
		#10;
		send_request(build_packet(zverif_pkg::op_write, 32'h0, 32'h1234_5678));
		repeat (20) @(posedge clk);
		assert (!umi_ready_rx) else log_failure("request port still ready after trap");
		assert (rsp_count == n_req) else log_failure("response count differs from request count");
		assert (trace_count == n_req) else log_failure("trace count differs from request count");
		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the run did not complete", cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* zverif_top.f */
src/zverif_pkg.sv
src/umi_msg_if.sv
src/umi_rx_port.sv
src/word_mem.sv
src/umi_endpoint_ctrl.sv
src/umi_tx_port.sv
src/zverif_top.sv
test/zverif_tb.sv
